//--- icache_settings.svh
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// fetch address and data width
`define ICACHE_XLEN 32

// 8 KB direct mapped, 128 lines of 64 bytes
// address split is tag | index | offset
`define ICACHE_TAG_W 19
`define ICACHE_INDEX_W 7
`define ICACHE_OFFSET_W 6

`define ICACHE_LINES 128
`define ICACHE_WORDS_PER_LINE 16

// refill burst length field, beats minus one
`define ICACHE_BURST_LEN 15

// top nibble selects the uncached region
`define ICACHE_UNCACHE_W 4
`define ICACHE_UNCACHE_REGION 4'hA

`endif

//--- icache_pkg.sv
`default_nettype none

`include "icache_settings.svh"

package icache_pkg;

  // one fetch address, two decodings
  typedef union packed {
    // line view for the tag and data stores
    struct packed {
      logic [`ICACHE_TAG_W-1:0]      tag;
      logic [`ICACHE_INDEX_W-1:0]    index;
      logic [`ICACHE_OFFSET_W-3:0]   word_sel;
      logic [1:0]                    byte_sel;
    } line;
    // region view for the uncached check
    struct packed {
      logic [`ICACHE_UNCACHE_W-1:0]             id;
      logic [`ICACHE_XLEN-`ICACHE_UNCACHE_W-1:0] rest;
    } region;
  } icache_addr_u;

  // controller states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_REFILL,
    ST_UNCACHED
  } icache_state_e;

endpackage

`default_nettype wire

//--- icache_fill_if.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_settings.svh"

interface icache_fill_if;

  // one refill beat
  logic                          word_we;
  logic [`ICACHE_INDEX_W-1:0]    index;
  logic [`ICACHE_OFFSET_W-3:0]   word_sel;
  logic [`ICACHE_XLEN-1:0]       wdata;

  // tag update, pulses once after the last beat
  logic                          tag_we;
  logic [`ICACHE_TAG_W-1:0]      tag;

  modport ctrl (
    output word_we, index, word_sel, wdata, tag_we, tag
  );

  // tag store only needs the line and tag
  modport tag_store (
    input tag_we, index, tag
  );

  // data store takes the beats
  modport data_store (
    input word_we, index, word_sel, wdata
  );

endinterface

`default_nettype wire

//--- icache_tag_store.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_settings.svh"

module icache_tag_store import icache_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            lookup_en_i,
  input  icache_addr_u    lookup_addr_i,
  input  logic            flush_i,
  output logic            hit_o,
  icache_fill_if.tag_store fill
);

  // per line valid bit
  logic [`ICACHE_LINES-1:0]    valid_q;

  // stored tags
  logic [`ICACHE_TAG_W-1:0]    tag_mem [`ICACHE_LINES];

  // registered lookup address
  logic [`ICACHE_INDEX_W-1:0]  idx_q;
  logic [`ICACHE_TAG_W-1:0]    tag_q;

  // valid bits, cleared on reset or fence.i flush
  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      valid_q <= '0;
    end else if (fill.tag_we) begin
      valid_q[fill.index] <= 1'b1;
    end
  end

  // tag written once the whole line is in
  always_ff @(posedge clk) begin
    if (fill.tag_we) begin
      tag_mem[fill.index] <= fill.tag;
    end
  end

  // capture lookup address on the fetch accept edge
  // and again on the re-lookup after a refill
  always_ff @(posedge clk) begin
    if (lookup_en_i) begin
      idx_q <= lookup_addr_i.line.index;
      tag_q <= lookup_addr_i.line.tag;
    end
  end

  // compare against current array contents
  // so a tag write shows up at the next edge
  assign hit_o = valid_q[idx_q] && (tag_mem[idx_q] == tag_q);

endmodule

`default_nettype wire

//--- icache_data_store.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_settings.svh"

module icache_data_store import icache_pkg::*; (
  input  logic                     clk,
  input  logic                     lookup_en_i,
  input  icache_addr_u             lookup_addr_i,
  output logic [`ICACHE_XLEN-1:0]  rdata_o,
  icache_fill_if.data_store        fill
);

  localparam int WSEL_W = `ICACHE_OFFSET_W - 2;
  localparam int ADDR_W = `ICACHE_INDEX_W + WSEL_W;
  localparam int DEPTH  = `ICACHE_LINES * `ICACHE_WORDS_PER_LINE;

  // one word per entry, line index in the upper bits
  logic [`ICACHE_XLEN-1:0]  mem [DEPTH];

  logic [ADDR_W-1:0]        raddr;
  logic [ADDR_W-1:0]        waddr;
  logic [`ICACHE_XLEN-1:0]  rdata_q;

  assign raddr = {lookup_addr_i.line.index, lookup_addr_i.line.word_sel};
  assign waddr = {fill.index, fill.word_sel};

  // refill beat lands on the edge it is accepted
  always_ff @(posedge clk) begin
    if (fill.word_we) begin
      mem[waddr] <= fill.wdata;
    end
  end

  // registered read
  // holds its word between lookups, which keeps
  // the response stable under back-pressure
  always_ff @(posedge clk) begin
    if (lookup_en_i) begin
      rdata_q <= mem[raddr];
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- icache_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_settings.svh"

module icache_ctrl import icache_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  // fetch request
  input  logic                     fetch_valid_i,
  input  icache_addr_u             fetch_addr_i,
  output logic                     fetch_ready_o,
  // fetch response
  output logic                     rsp_valid_o,
  output logic [`ICACHE_XLEN-1:0]  rsp_data_o,
  input  logic                     rsp_ready_i,
  input  logic                     flush_i,
  // store lookup
  input  logic                     hit_i,
  input  logic [`ICACHE_XLEN-1:0]  rdata_i,
  output icache_addr_u             lookup_addr_o,
  output logic                     lookup_en_o,
  output logic                     flush_o,
  // memory request
  output logic                     mem_req_valid_o,
  output logic [`ICACHE_XLEN-1:0]  mem_req_addr_o,
  output logic [7:0]               mem_req_len_o,
  input  logic                     mem_req_ready_i,
  // memory data
  input  logic                     mem_rsp_valid_i,
  input  logic [`ICACHE_XLEN-1:0]  mem_rsp_data_i,
  output logic                     mem_rsp_ready_o,
  icache_fill_if.ctrl              fill
);

  localparam int WSEL_W = `ICACHE_OFFSET_W - 2;
  localparam logic [WSEL_W-1:0] LAST_BEAT = WSEL_W'(`ICACHE_BURST_LEN);

  icache_state_e            state_q;
  icache_state_e            state_d;

  // mirrors state_q == ST_IDLE, but low during reset
  logic                     ready_q;

  // accepted fetch address
  icache_addr_u             addr_q;

  logic                     accept;
  logic                     uncached;
  logic                     miss_start;
  logic                     expect_beat;
  logic                     beat;
  logic                     last_beat;
  logic                     unc_fire;

  logic                     mem_req_valid_q;
  logic [`ICACHE_XLEN-1:0]  mem_req_addr_q;
  logic [7:0]               mem_req_len_q;

  logic [WSEL_W-1:0]        beat_cnt_q;
  logic                     tag_we_q;

  // single beat uncached response
  logic                     unc_valid_q;
  logic [`ICACHE_XLEN-1:0]  unc_data_q;

  assign accept   = fetch_valid_i && ready_q;
  assign uncached = (addr_q.region.id == `ICACHE_UNCACHE_REGION);

  // lookup done without a usable hit, memory needed
  assign miss_start = (state_q == ST_LOOKUP) && (uncached || !hit_i);

  // data is only expected once the request went out
  // and until the burst or single beat is complete
  assign expect_beat = !mem_req_valid_q &&
                       (((state_q == ST_REFILL) && !tag_we_q) ||
                        ((state_q == ST_UNCACHED) && !unc_valid_q));
  assign beat      = mem_rsp_valid_i && expect_beat;
  assign last_beat = beat && (state_q == ST_REFILL) && (beat_cnt_q == LAST_BEAT);
  assign unc_fire  = (state_q == ST_UNCACHED) && unc_valid_q && rsp_ready_i;

  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (accept) begin
          state_d = ST_LOOKUP;
        end
      end
      ST_LOOKUP: begin
        if (uncached) begin
          state_d = ST_UNCACHED;
        end else if (!hit_i) begin
          state_d = ST_REFILL;
        end else if (rsp_ready_i) begin
          state_d = ST_IDLE;
        end
      end
      ST_REFILL: begin
        // tag write cycle doubles as the re-lookup
        if (tag_we_q) begin
          state_d = ST_LOOKUP;
        end
      end
      ST_UNCACHED: begin
        if (unc_fire) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  // control state
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q         <= ST_IDLE;
      ready_q         <= 1'b0;
      mem_req_valid_q <= 1'b0;
      beat_cnt_q      <= '0;
      tag_we_q        <= 1'b0;
      unc_valid_q     <= 1'b0;
    end else begin
      state_q  <= state_d;
      ready_q  <= (state_d == ST_IDLE);
      tag_we_q <= last_beat;
      // request held until memory takes it
      if (miss_start) begin
        mem_req_valid_q <= 1'b1;
      end else if (mem_req_ready_i) begin
        mem_req_valid_q <= 1'b0;
      end
      // beat counter restarts with every lookup
      if (state_q == ST_LOOKUP) begin
        beat_cnt_q <= '0;
      end else if (beat) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end
      if (beat && (state_q == ST_UNCACHED)) begin
        unc_valid_q <= 1'b1;
      end else if (unc_fire) begin
        unc_valid_q <= 1'b0;
      end
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q <= fetch_addr_i;
    end
    if (miss_start) begin
      if (uncached) begin
        // exact word, one beat
        mem_req_addr_q <= addr_q;
        mem_req_len_q  <= 8'd0;
      end else begin
        // line aligned burst
        mem_req_addr_q <= {addr_q.line.tag, addr_q.line.index, {`ICACHE_OFFSET_W{1'b0}}};
        mem_req_len_q  <= 8'(`ICACHE_BURST_LEN);
      end
    end
    if (beat && (state_q == ST_UNCACHED)) begin
      unc_data_q <= mem_rsp_data_i;
    end
  end

  assign fetch_ready_o = ready_q;

  // store reads on accept, or on re-lookup after refill
  assign lookup_en_o   = accept || ((state_q == ST_REFILL) && tag_we_q);
  assign lookup_addr_o = (state_q == ST_IDLE) ? fetch_addr_i : addr_q;

  // fence.i only while idle and not fetching
  assign flush_o = ready_q && flush_i && !fetch_valid_i;

  // hit word straight from the data store register
  assign rsp_valid_o = ((state_q == ST_LOOKUP) && !uncached && hit_i) ||
                       ((state_q == ST_UNCACHED) && unc_valid_q);
  assign rsp_data_o  = (state_q == ST_UNCACHED) ? unc_data_q : rdata_i;

  assign mem_req_valid_o = mem_req_valid_q;
  assign mem_req_addr_o  = mem_req_addr_q;
  assign mem_req_len_o   = mem_req_len_q;
  assign mem_rsp_ready_o = expect_beat;

  // line fill path
  assign fill.word_we  = beat && (state_q == ST_REFILL);
  assign fill.index    = addr_q.line.index;
  assign fill.word_sel = beat_cnt_q;
  assign fill.wdata    = mem_rsp_data_i;
  assign fill.tag_we   = tag_we_q;
  assign fill.tag      = addr_q.line.tag;

endmodule

`default_nettype wire

//--- icache_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_settings.svh"

module icache_top import icache_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  // fetch request
  input  logic                     fetch_valid_i,
  input  icache_addr_u             fetch_addr_i,
  output logic                     fetch_ready_o,
  // fetch response
  output logic                     rsp_valid_o,
  output logic [`ICACHE_XLEN-1:0]  rsp_data_o,
  input  logic                     rsp_ready_i,
  // fence.i
  input  logic                     flush_i,
  // memory request
  output logic                     mem_req_valid_o,
  output logic [`ICACHE_XLEN-1:0]  mem_req_addr_o,
  output logic [7:0]               mem_req_len_o,
  input  logic                     mem_req_ready_i,
  // memory data
  input  logic                     mem_rsp_valid_i,
  input  logic [`ICACHE_XLEN-1:0]  mem_rsp_data_i,
  output logic                     mem_rsp_ready_o
);

  // controller to store wiring
  logic                     hit;
  logic [`ICACHE_XLEN-1:0]  rdata;
  icache_addr_u             lookup_addr;
  logic                     lookup_en;
  logic                     flush;

  // refill writes into both stores
  icache_fill_if fill ();

  icache_ctrl u_ctrl (
    .clk             (clk),
    .rst             (rst),
    .fetch_valid_i   (fetch_valid_i),
    .fetch_addr_i    (fetch_addr_i),
    .fetch_ready_o   (fetch_ready_o),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_data_o      (rsp_data_o),
    .rsp_ready_i     (rsp_ready_i),
    .flush_i         (flush_i),
    .hit_i           (hit),
    .rdata_i         (rdata),
    .lookup_addr_o   (lookup_addr),
    .lookup_en_o     (lookup_en),
    .flush_o         (flush),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_addr_o  (mem_req_addr_o),
    .mem_req_len_o   (mem_req_len_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_data_i  (mem_rsp_data_i),
    .mem_rsp_ready_o (mem_rsp_ready_o),
    .fill            (fill.ctrl)
  );

  icache_tag_store u_tag_store (
    .clk           (clk),
    .rst           (rst),
    .lookup_en_i   (lookup_en),
    .lookup_addr_i (lookup_addr),
    .flush_i       (flush),
    .hit_o         (hit),
    .fill          (fill.tag_store)
  );

  icache_data_store u_data_store (
    .clk           (clk),
    .lookup_en_i   (lookup_en),
    .lookup_addr_i (lookup_addr),
    .rdata_o       (rdata),
    .fill          (fill.data_store)
  );

endmodule

`default_nettype wire

//--- tb_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mem_model #(
  parameter int DRIVE_DELAY = 1
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        req_valid_i,
  input  logic [31:0] req_addr_i,
  input  logic [7:0]  req_len_i,
  output logic        req_ready_o,
  output logic        rsp_valid_o,
  output logic [31:0] rsp_data_o,
  input  logic        rsp_ready_i,
  // stall bits from the testbench LFSR
  input  logic        req_stall_i,
  input  logic        rsp_stall_i
);

  logic        busy;
  logic        in_reset;
  logic        req_stall;
  logic        rsp_stall;
  logic [31:0] addr;
  logic [7:0]  left;

  initial begin
    busy        = 1'b0;
    addr        = '0;
    left        = '0;
    req_ready_o = 1'b0;
    rsp_valid_o = 1'b0;
    rsp_data_o  = '0;
    forever begin
      @(posedge clk);
      // everything sampled at the edge
      in_reset  = rst;
      req_stall = req_stall_i;
      rsp_stall = rsp_stall_i;
      if (in_reset) begin
        busy = 1'b0;
      end else if (!busy && req_valid_i && req_ready_o) begin
        busy = 1'b1;
        addr = req_addr_i;
        left = req_len_i;
      end else if (busy && rsp_valid_o && rsp_ready_i) begin
        // next beat of the burst, or done
        if (left == 8'd0) begin
          busy = 1'b0;
        end else begin
          left = left - 8'd1;
          addr = addr + 32'd4;
        end
      end
      #(DRIVE_DELAY);
      req_ready_o = !in_reset && !busy && !req_stall;
      rsp_valid_o = busy && !rsp_stall;
      // each beat carries its byte address inverted
      rsp_data_o  = ~addr;
    end
  end

endmodule

`default_nettype wire

//--- tb_icache.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_settings.svh"

module tb_icache;

  localparam int CLK_PERIOD   = 100;
  localparam int DRIVE_DELAY  = 1;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_FETCHES  = 27;
  // worst case per fetch is a burst with a stall run on every beat
  localparam int MAX_STALL    = 32;
  localparam int REQ_BOUND    = (`ICACHE_BURST_LEN + 3) * (MAX_STALL + 1);
  localparam int TIMEOUT_CYC  = RESET_CYCLES + NUM_FETCHES * REQ_BOUND;
  localparam logic [31:0] SEED = 32'hf58a_8df2;

  logic        clk;
  logic        rst;
  logic        fetch_valid;
  logic [31:0] fetch_addr;
  logic        fetch_ready;
  logic        rsp_valid;
  logic [31:0] rsp_data;
  logic        rsp_ready;
  logic        flush;
  logic        mem_req_valid;
  logic [31:0] mem_req_addr;
  logic [7:0]  mem_req_len;
  logic        mem_req_ready;
  logic        mem_rsp_valid;
  logic [31:0] mem_rsp_data;
  logic        mem_rsp_ready;
  logic        req_stall;
  logic        rsp_stall;
  logic [31:0] lfsr;

  int          check_errors = 0;
  int          mon_errors = 0;
  int          prop_errors = 0;
  int          fetch_count = 0;
  int          req_count = 0;
  logic [31:0] last_req_addr = '0;
  logic [7:0]  last_req_len = '0;
  logic        hold_pending = 1'b0;
  logic [31:0] held_data = '0;

  icache_top dut0 (
    .clk             (clk),
    .rst             (rst),
    .fetch_valid_i   (fetch_valid),
    .fetch_addr_i    (fetch_addr),
    .fetch_ready_o   (fetch_ready),
    .rsp_valid_o     (rsp_valid),
    .rsp_data_o      (rsp_data),
    .rsp_ready_i     (rsp_ready),
    .flush_i         (flush),
    .mem_req_valid_o (mem_req_valid),
    .mem_req_addr_o  (mem_req_addr),
    .mem_req_len_o   (mem_req_len),
    .mem_req_ready_i (mem_req_ready),
    .mem_rsp_valid_i (mem_rsp_valid),
    .mem_rsp_data_i  (mem_rsp_data),
    .mem_rsp_ready_o (mem_rsp_ready)
  );

  tb_mem_model #(.DRIVE_DELAY(DRIVE_DELAY)) mem0 (
    .clk         (clk),
    .rst         (rst),
    .req_valid_i (mem_req_valid),
    .req_addr_i  (mem_req_addr),
    .req_len_i   (mem_req_len),
    .req_ready_o (mem_req_ready),
    .rsp_valid_o (mem_rsp_valid),
    .rsp_data_o  (mem_rsp_data),
    .rsp_ready_i (mem_rsp_ready),
    .req_stall_i (req_stall),
    .rsp_stall_i (rsp_stall)
  );

  // fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // random stalls and response back-pressure with one step per bit
  initial begin
    lfsr      = SEED;
    req_stall = 1'b0;
    rsp_stall = 1'b0;
    rsp_ready = 1'b0;
    forever begin
      @(posedge clk);
      #(DRIVE_DELAY);
      lfsr      = lfsr_step(lfsr);
      req_stall = lfsr[0];
      lfsr      = lfsr_step(lfsr);
      rsp_stall = lfsr[0];
      lfsr      = lfsr_step(lfsr);
      rsp_ready = lfsr[0];
    end
  end

  // request log, response hold and ready exclusion
  always @(posedge clk) begin
    if (!rst) begin
      if (mem_req_valid && mem_req_ready) begin
        req_count     = req_count + 1;
        last_req_addr = mem_req_addr;
        last_req_len  = mem_req_len;
      end
      if (hold_pending) begin
        assert (rsp_valid) else begin
          mon_errors++;
          $display("error rsp_valid_o: got %h expected %h", rsp_valid, 1'b1);
        end
        assert (rsp_data === held_data) else begin
          mon_errors++;
          $display("error rsp_data_o: got %h expected %h", rsp_data, held_data);
        end
      end
      assert (!(rsp_valid && fetch_ready)) else begin
        mon_errors++;
        $display("fetch_ready_o was high while a response was pending");
      end
      // memory data only taken once the request is out and before the response
      assert (!(mem_rsp_ready && (mem_req_valid || fetch_ready || rsp_valid))) else begin
        mon_errors++;
        $display("mem_rsp_ready_o was high while no memory data was expected");
      end
      hold_pending = rsp_valid && !rsp_ready;
      held_data    = rsp_data;
    end
  end

  // memory request held until accepted
  req_hold: assert property (@(posedge clk) disable iff (rst)
    (mem_req_valid && !mem_req_ready) |=>
      (mem_req_valid && $stable(mem_req_addr) && $stable(mem_req_len)))
    else begin
      prop_errors++;
      $display("memory request dropped or changed before it was accepted");
    end

  // one fetch started one drive delay after an edge with the cache idle
  task automatic do_fetch(input logic [31:0] addr, input bit exp_miss);
    logic [31:0] exp_data;
    logic [31:0] exp_addr;
    logic [7:0]  exp_len;
    int          reqs_before;
    exp_data = ~{addr[31:2], 2'b00};
    if (addr[31:28] == `ICACHE_UNCACHE_REGION) begin
      exp_addr = addr;
      exp_len  = 8'd0;
    end else begin
      exp_addr = {addr[31:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};
      exp_len  = 8'(`ICACHE_BURST_LEN);
    end
    reqs_before = req_count;
    fetch_valid = 1'b1;
    fetch_addr  = addr;
    do begin
      @(posedge clk);
    end while (!fetch_ready);
    #(DRIVE_DELAY);
    fetch_valid = 1'b0;
    @(posedge clk);
    // a hit answers in the cycle after acceptance
    if (!exp_miss) begin
      assert (rsp_valid) else begin
        check_errors++;
        $display("error rsp_valid_o: got %h expected %h", rsp_valid, 1'b1);
      end
    end
    while (!(rsp_valid && rsp_ready)) @(posedge clk);
    assert (rsp_data === exp_data) else begin
      check_errors++;
      $display("error rsp_data_o: got %h expected %h", rsp_data, exp_data);
    end
    #(DRIVE_DELAY);
    fetch_count++;
    assert (req_count - reqs_before == (exp_miss ? 1 : 0)) else begin
      check_errors++;
      $display("fetch %h made %0d memory requests", addr, req_count - reqs_before);
    end
    if (exp_miss) begin
      assert (last_req_addr === exp_addr && last_req_len === exp_len) else begin
        check_errors++;
        $display("error mem_req_addr_o: got %h expected %h", last_req_addr, exp_addr);
        $display("error mem_req_len_o: got %h expected %h", last_req_len, exp_len);
      end
    end
  endtask

  // one cycle of flush while idle
  task automatic flush_cache();
    flush = 1'b1;
    @(posedge clk);
    #(DRIVE_DELAY);
    flush = 1'b0;
  endtask

  initial begin
    #(TIMEOUT_CYC * CLK_PERIOD);
    $display("timeout after %0d cycles, a handshake never completed", TIMEOUT_CYC);
    $display("Verification failed");
    $finish;
  end

  initial begin
    rst         = 1'b1;
    fetch_valid = 1'b0;
    fetch_addr  = '0;
    flush       = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DELAY);
    rst = 1'b0;
    assert (!fetch_ready && !rsp_valid && !mem_req_valid && !mem_rsp_ready) else begin
      check_errors++;
      $display("outputs were not low at the end of reset");
    end
    @(posedge clk);
    #(DRIVE_DELAY);
    assert (fetch_ready) else begin
      check_errors++;
      $display("error fetch_ready_o: got %h expected %h", fetch_ready, 1'b1);
    end
    // miss then hits in the same line
    do_fetch(32'h0000_1040, 1'b1);
    do_fetch(32'h0000_1044, 1'b0);
    do_fetch(32'h0000_107c, 1'b0);
    do_fetch(32'h0000_1040, 1'b0);
    // uncached region never stored
    do_fetch(32'ha000_0124, 1'b1);
    do_fetch(32'ha000_0124, 1'b1);
    // same index with another tag
    do_fetch(32'h0000_3040, 1'b1);
    do_fetch(32'h0000_1048, 1'b1);
    do_fetch(32'h0000_104c, 1'b0);
    // fence.i
    flush_cache();
    do_fetch(32'h0000_1050, 1'b1);
    do_fetch(32'h0000_1054, 1'b0);
    // several lines filled then hit under random stalls
    for (int i = 0; i < 8; i++) begin
      do_fetch(32'h0000_8000 + 32'(i) * 64 + 32'(i % 16) * 4, 1'b1);
    end
    for (int i = 0; i < 8; i++) begin
      do_fetch(32'h0000_8000 + 32'(i) * 64 + 32'((i * 5 + 3) % 16) * 4, 1'b0);
    end
    $display("summary: fetches %0d requests %0d errors check %0d monitor %0d property %0d",
             fetch_count, req_count, check_errors, mon_errors, prop_errors);
    if (check_errors == 0 && mon_errors == 0 && prop_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+.
icache_pkg.sv
icache_fill_if.sv
icache_tag_store.sv
icache_data_store.sv
icache_ctrl.sv
icache_top.sv
tb_mem_model.sv
tb_icache.sv

//--- run.sh
#!/bin/sh
# build with verilator, run, then search the log for the fail message
rm -f sim.log \
  && verilator --binary --timing --assert -j 0 --top-module tb_icache -f project.f -o sim_icache \
  && { ./obj_dir/sim_icache > sim.log; cat sim.log; } \
  && ! grep -q "Verification failed" sim.log \
  || { echo "run failed"; exit 1; }
echo "run passed"
